// File: tictactoe_params.svh
`ifndef TICTACTOE_PARAMS_SVH
`define TICTACTOE_PARAMS_SVH

// ------------------------------------------------------------
// Keyboard scan codes, set 2 make codes.
// ------------------------------------------------------------
`define KEY_W      8'h1D   // Up.
`define KEY_A      8'h1C   // Left.
`define KEY_S      8'h1B   // Down.
`define KEY_D      8'h23   // Right.
`define KEY_R      8'h2D   // Restart.
`define KEY_ENTER  8'h5A   // Place.

// ------------------------------------------------------------
// Grid geometry.
// ------------------------------------------------------------
`define GRID_SIZE  3

// ------------------------------------------------------------
// Bus register word addresses.
// ------------------------------------------------------------
`define ADR_BOARD  0
`define ADR_STATUS 1

`endif

// File: tictactoePkg.sv
`include "tictactoe_params.svh"

package tictactoePkg;

   // Cell contents; empty must stay zero so a cleared board reads as zero.
   typedef enum logic [1:0] {
      cellEmpty = 2'd0,
      cellX     = 2'd1,
      cellO     = 2'd2
   } cellT;

   typedef logic [1:0] posT;   // Grid coordinate, 0 to 2.

   // Row-major, cell (row, col) at index row*GRID_SIZE + col.
   typedef cellT [`GRID_SIZE*`GRID_SIZE-1:0] boardT;

   typedef enum logic [2:0] {
      cmdNone    = 3'd0,
      cmdUp      = 3'd1,
      cmdDown    = 3'd2,
      cmdLeft    = 3'd3,
      cmdRight   = 3'd4,
      cmdRestart = 3'd5,
      cmdPlace   = 3'd6
   } keyCmdT;

   typedef struct packed {
      logic win;
      cellT symbol;   // Empty unless win.
   } lineResultT;

   typedef struct packed {
      posT        cursorX;
      posT        cursorY;
      logic [3:0] moveCount;
      cellT       winner;
      logic       gameOver;
      logic       draw;
      cellT       turn;   // Symbol of the next move.
   } statusT;

endpackage

// File: keyDecoder.sv
`include "tictactoe_params.svh"

module keyDecoder
   import tictactoePkg::*;
(
   input  logic       Clock,
   input  logic       arstN,
   input  logic [7:0] keyData,
   input  logic       keyboardFlag,
   output keyCmdT     cmd,
   output logic       keyboardReset
);

   logic   flagMeta;
   logic   flagSync;
   logic   flagPrev;
   logic   flagFall;
   keyCmdT decoded;

   // Flag idles high, so the flops reset high to avoid a false edge.
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         flagMeta <= 1'b1;
         flagSync <= 1'b1;
         flagPrev <= 1'b1;
      end else begin
         flagMeta <= keyboardFlag;
         flagSync <= flagMeta;
         flagPrev <= flagSync;
      end
   end

   assign flagFall = flagPrev & ~flagSync;

   // keyData is held stable by the keyboard until it is released.
   always_comb begin
      case (keyData)
         `KEY_W:     decoded = cmdUp;
         `KEY_S:     decoded = cmdDown;
         `KEY_A:     decoded = cmdLeft;
         `KEY_D:     decoded = cmdRight;
         `KEY_R:     decoded = cmdRestart;
         `KEY_ENTER: decoded = cmdPlace;
         default:    decoded = cmdNone;
      endcase
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         cmd           <= cmdNone;
         keyboardReset <= 1'b0;
      end else begin
         cmd           <= flagFall ? decoded : cmdNone;
         keyboardReset <= flagFall;   // Released even for unknown codes.
      end
   end

endmodule

// File: gameBoard.sv
`include "tictactoe_params.svh"

module gameBoard
   import tictactoePkg::*;
(
   input  logic   Clock,
   input  logic   arstN,
   input  keyCmdT cmd,
   input  cellT   winner,
   input  logic   draw,
   output boardT  board,
   output statusT status
);

   localparam posT maxPos = posT'(`GRID_SIZE - 1);

   boardT      cells;
   posT        cursorX;
   posT        cursorY;
   logic [3:0] moveCount;
   logic [3:0] curIdx;
   logic       gameOver;
   cellT       nextSym;

   assign curIdx   = cursorY * 4'(`GRID_SIZE) + cursorX;
   assign gameOver = (winner != cellEmpty) || draw;
   assign nextSym  = moveCount[0] ? cellO : cellX;   // x always opens.

   // ------------------------------------------------------------
   // Cursor, cells and move counter.
   // ------------------------------------------------------------
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         cells     <= boardT'('0);
         cursorX   <= posT'(1);
         cursorY   <= posT'(1);
         moveCount <= 4'd0;
      end else begin
         case (cmd)
            cmdUp: begin
               if (cursorY != 2'd0) cursorY <= cursorY - 2'd1;
            end
            cmdDown: begin
               if (cursorY != maxPos) cursorY <= cursorY + 2'd1;
            end
            cmdLeft: begin
               if (cursorX != 2'd0) cursorX <= cursorX - 2'd1;
            end
            cmdRight: begin
               if (cursorX != maxPos) cursorX <= cursorX + 2'd1;
            end
            cmdRestart: begin
               cells     <= boardT'('0);   // Cursor keeps its place.
               moveCount <= 4'd0;
            end
            cmdPlace: begin
               // Refused once the game is decided or the cell is taken.
               if (!gameOver && cells[curIdx] == cellEmpty) begin
                  cells[curIdx] <= nextSym;
                  moveCount     <= moveCount + 4'd1;
               end
            end
            default: ;
         endcase
      end
   end

   assign board = cells;

   // Outcome fields are completed at the top level.
   always_comb begin
      status           = '0;
      status.cursorX   = cursorX;
      status.cursorY   = cursorY;
      status.moveCount = moveCount;
      status.winner    = cellEmpty;
      status.gameOver  = 1'b0;
      status.draw      = 1'b0;
      status.turn      = nextSym;
   end

endmodule

// File: lineChecker.sv
`include "tictactoe_params.svh"

module lineChecker
   import tictactoePkg::*;
#(
   parameter int lineIndex = 0   // 0-2 rows, 3-5 columns, 6-7 diagonals.
) (
   input  boardT      board,
   output lineResultT result
);

   localparam int n = `GRID_SIZE;

   // First cell and stride of the selected line.
   localparam int first = (lineIndex < 3) ? lineIndex * n :
                          (lineIndex < 6) ? lineIndex - 3 :
                          (lineIndex == 6) ? 0 : n - 1;
   localparam int step  = (lineIndex < 3) ? 1 :
                          (lineIndex < 6) ? n :
                          (lineIndex == 6) ? n + 1 : n - 1;

   cellT c0, c1, c2;

   assign c0 = board[first];
   assign c1 = board[first + step];
   assign c2 = board[first + 2*step];

   assign result.win    = (c0 != cellEmpty) && (c0 == c1) && (c1 == c2);
   assign result.symbol = result.win ? c0 : cellEmpty;

endmodule

// File: winArbiter.sv
module winArbiter
   import tictactoePkg::*;
(
   input  lineResultT [7:0] lineResults,
   input  boardT            board,
   output cellT             winner,
   output logic             draw
);

   logic full;

   // Lowest winning line takes priority, so scan downward.
   always_comb begin
      winner = cellEmpty;
      for (int i = 7; i >= 0; i--) begin
         if (lineResults[i].win) winner = lineResults[i].symbol;
      end
   end

   always_comb begin
      full = 1'b1;
      for (int i = 0; i < $size(board); i++) begin
         if (board[i] == cellEmpty) full = 1'b0;
      end
   end

   assign draw = full && (winner == cellEmpty);   // A last-move win is no draw.

endmodule

// File: boardBusSlave.sv
`include "tictactoe_params.svh"

module boardBusSlave
   import tictactoePkg::*;
(
   input  logic        Clock,
   input  logic        arstN,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [1:0]  adr,
   input  logic [31:0] datWr,
   input  boardT       board,
   input  statusT      status,
   output logic [31:0] datRd,
   output logic        ack
);

   logic        req;
   logic [31:0] readWord;

   assign req = cyc & stb;

   // ------------------------------------------------------------
   // Register map.
   // ------------------------------------------------------------
   always_comb begin
      case (adr)
         2'(`ADR_BOARD):  readWord = 32'(board);
         2'(`ADR_STATUS): readWord = 32'(status);
         default:         readWord = 32'd0;
      endcase
   end

   // Held high while the master keeps stb up.
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN)
         ack <= 1'b0;
      else
         ack <= req;
   end

   // Host writes are acknowledged only; datWr goes nowhere.
   always_ff @(posedge Clock) begin
      if (req)
         datRd <= we ? 32'd0 : readWord;
   end

endmodule

// File: tictactoeTop.sv
module tictactoeTop
   import tictactoePkg::*;
(
   input  logic        Clock,
   input  logic        arstN,
   input  logic [7:0]  keyData,
   input  logic        keyboardFlag,
   output logic        keyboardReset,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [1:0]  adr,
   input  logic [31:0] datWr,
   output logic [31:0] datRd,
   output logic        ack
);

   keyCmdT           cmd;
   boardT            board;
   statusT           boardStatus;
   statusT           fullStatus;
   lineResultT [7:0] lineResults;
   cellT             winner;
   logic             draw;

   keyDecoder keyDecoder0 (
      .Clock         (Clock),
      .arstN         (arstN),
      .keyData       (keyData),
      .keyboardFlag  (keyboardFlag),
      .cmd           (cmd),
      .keyboardReset (keyboardReset)
   );

   gameBoard gameBoard0 (
      .Clock  (Clock),
      .arstN  (arstN),
      .cmd    (cmd),
      .winner (winner),
      .draw   (draw),
      .board  (board),
      .status (boardStatus)
   );

   // ------------------------------------------------------------
   // One checker per row, column and diagonal.
   // ------------------------------------------------------------
   for (genvar i = 0; i < 8; i++) begin : genLine
      lineChecker #(.lineIndex(i)) lineChecker0 (
         .board  (board),
         .result (lineResults[i])
      );
   end

   winArbiter winArbiter0 (
      .lineResults (lineResults),
      .board       (board),
      .winner      (winner),
      .draw        (draw)
   );

   always_comb begin
      fullStatus          = boardStatus;
      fullStatus.winner   = winner;
      fullStatus.gameOver = (winner != cellEmpty) || draw;
      fullStatus.draw     = draw;
   end

   boardBusSlave boardBusSlave0 (
      .Clock  (Clock),
      .arstN  (arstN),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .datWr  (datWr),
      .board  (board),
      .status (fullStatus),
      .datRd  (datRd),
      .ack    (ack)
   );

endmodule

// File: tbChecker.sv
module tbChecker (
   input logic        Clock,
   input logic        ack,
   input logic [1:0]  adr,
   input logic [31:0] datRd,
   input logic [31:0] expData,
   input logic        keyboardFlag,
   input logic        keyboardReset
);

   int           passCount    = 0;
   int           failCount    = 0;
   int           releaseFails = 0;
   int           testPass     = 0;
   int           testFail     = 0;
   int           flagCycles   = -1;
   logic         flagLast     = 1'b1;
   logic         inTest       = 1'b0;
   logic         ackSeen      = 1'b0;
   logic [127:0] testName     = '0;

   // ------------------------------------------------------------
   // One compare per ack pulse, taken on the falling edge.
   // ------------------------------------------------------------
   always @(negedge Clock) begin
      if (ack === 1'b1 && !ackSeen) begin
         if (datRd === expData) begin
            passCount++;
            testPass++;
         end else begin
            $display("Fail %0t: %0s, word %0d read %h, expected %h",
                     $time, testName, adr, datRd, expData);
            failCount++;
            testFail++;
         end
      end
      ackSeen = (ack === 1'b1);
   end

   // ------------------------------------------------------------
   // Keyboard release, a single pulse three cycles after the flag falls.
   // ------------------------------------------------------------
   always @(negedge Clock) begin
      if (flagCycles >= 0)
         flagCycles++;
      if (flagLast === 1'b1 && keyboardFlag === 1'b0)
         flagCycles = 0;
      flagLast = keyboardFlag;
      if (keyboardReset === 1'b1) begin
         if (flagCycles < 0) begin
            $display("Fail %0t: keyboard release without a pending key press", $time);
            releaseFails++;
            testFail++;
         end else if (flagCycles != 3) begin
            $display("Fail %0t: keyboard release %0d cycles after flag fall, expected 3",
                     $time, flagCycles);
            releaseFails++;
            testFail++;
         end
         flagCycles = -1;
      end
   end

   task automatic closeTest();
      if (inTest) begin
         $display("test %0s: %0d reads matched, %0d checks failed",
                  testName, testPass, testFail);
      end
      inTest = 1'b0;
   endtask

   task automatic startTest(input logic [127:0] name);
      closeTest();   // Reports the test before it.
      testName = name;
      testPass = 0;
      testFail = 0;
      inTest   = 1'b1;
   endtask

endmodule

// File: tbTictactoe.sv
module tbTictactoe;

   logic         Clock;
   logic         arstN;
   logic [7:0]   keyData;
   logic         keyboardFlag;
   logic         keyboardReset;
   logic         cyc;
   logic         stb;
   logic         we;
   logic [1:0]   adr;
   logic [31:0]  datWr;
   logic [31:0]  datRd;
   logic         ack;
   logic [31:0]  expData;
   logic         traceOk;

   // Parsed trace, one entry per command line.
   logic [7:0]   kindQ[$];
   logic [31:0]  argAQ[$];
   logic [31:0]  argBQ[$];
   logic [127:0] nameQ[$];

   int           cycleCount = 0;
   int           cycleLimit = 200;
   int           readCount  = 0;

   tictactoeTop dut0 (
      .Clock         (Clock),
      .arstN         (arstN),
      .keyData       (keyData),
      .keyboardFlag  (keyboardFlag),
      .keyboardReset (keyboardReset),
      .cyc           (cyc),
      .stb           (stb),
      .we            (we),
      .adr           (adr),
      .datWr         (datWr),
      .datRd         (datRd),
      .ack           (ack)
   );

   tbChecker check0 (
      .Clock         (Clock),
      .ack           (ack),
      .adr           (adr),
      .datRd         (datRd),
      .expData       (expData),
      .keyboardFlag  (keyboardFlag),
      .keyboardReset (keyboardReset)
   );

   always #10 Clock = ~Clock;

   initial begin : watchdog
      @(posedge Clock);
      while (cycleCount < cycleLimit) begin
         @(posedge Clock);
         cycleCount++;
      end
      $display("timeout: trace did not finish");
      $display("tests failed");
      $finish;
   end

   // ------------------------------------------------------------
   // Trace reader and drivers.
   // ------------------------------------------------------------
   task automatic readTrace(output logic ok);
      int           fd;
      int           c;
      logic [7:0]   tag;
      logic [31:0]  a;
      logic [31:0]  b;
      logic [127:0] name;
      fd = $fopen("tictactoe_trace.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while ($fscanf(fd, "%s", tag) == 1) begin
            a    = '0;
            b    = '0;
            name = '0;
            case (tag)
               "K": c = $fscanf(fd, "%h", a);
               "R": c = $fscanf(fd, "%h %h", a, b);
               "T": c = $fscanf(fd, "%s", name);
               default: begin
                  do c = $fgetc(fd); while (c != "\n" && c != -1);   // Comment line.
               end
            endcase
            if (tag == "K" || tag == "R" || tag == "T") begin
               kindQ.push_back(tag);
               argAQ.push_back(a);
               argBQ.push_back(b);
               nameQ.push_back(name);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic pressKey(input logic [7:0] code);
      @(posedge Clock);
      #2;
      keyData      = code;
      keyboardFlag = 1'b0;
      do @(negedge Clock); while (keyboardReset !== 1'b1);
      repeat (2) @(posedge Clock);
      #2 keyboardFlag = 1'b1;
   endtask

   task automatic busRead(input logic [1:0] address, input logic [31:0] expected);
      @(posedge Clock);
      #2;
      cyc     = 1'b1;
      stb     = 1'b1;
      we      = 1'b0;
      adr     = address;
      expData = expected;   // Checker compares on the first ack.
      do @(negedge Clock); while (ack !== 1'b1);
      @(posedge Clock);
      #2;
      cyc = 1'b0;
      stb = 1'b0;
      do @(negedge Clock); while (ack !== 1'b0);
      readCount++;
   endtask

   initial begin
      Clock        = 1'b0;
      arstN        = 1'b0;
      keyData      = 8'h00;
      keyboardFlag = 1'b1;   // Idles high.
      cyc          = 1'b0;
      stb          = 1'b0;
      we           = 1'b0;
      adr          = 2'd0;
      datWr        = 32'd0;
      expData      = 32'd0;
      readTrace(traceOk);
      cycleLimit = 40 * kindQ.size() + 200;
      if (!traceOk) begin
         $display("could not open the trace file tictactoe_trace.txt");
         $display("tests failed");
         $finish;
      end else begin
         repeat (8) @(posedge Clock);
         #2 arstN = 1'b1;
         for (int i = 0; i < kindQ.size(); i++) begin
            case (kindQ[i])
               "K":     pressKey(argAQ[i][7:0]);
               "R":     busRead(argAQ[i][1:0], argBQ[i]);
               default: check0.startTest(nameQ[i]);
            endcase
         end
         check0.closeTest();
         $display("%0d reads matched, %0d mismatched, %0d release errors, %0d issued",
                  check0.passCount, check0.failCount, check0.releaseFails, readCount);
         if (check0.failCount == 0 && check0.releaseFails == 0 &&
             check0.passCount == readCount) begin
            $display("all tests passed");
         end else begin
            if (check0.passCount + check0.failCount != readCount)
               $display("some bus reads never reached the checker");
            $display("tests failed");
         end
         $finish;
      end
   end

endmodule

// File: tictactoe_trace.txt
# K <scan code>, R <word address> <expected read data>; all values hex.
# T <test name> starts a new test.
T reset
R 0 00000000
R 1 00001401
R 2 00000000
T cursor
K 23
K 23
K 23
R 1 00002401
K 1d
K 1d
K 1d
R 1 00002001
T place
K 5a
K 5a
R 0 00000010
R 1 00002042
K 1c
K 5a
R 0 00000018
R 1 00001081
T win
K 1b
K 5a
K 1c
K 5a
K 1b
K 5a
R 1 0000095a
K 23
K 5a
R 1 0000195a
R 0 00001198
T restart
K 2d
R 0 00000000
R 1 00001801
K 15
R 1 00001801
T draw
K 5a
K 1d
K 5a
K 1c
K 5a
K 1b
K 5a
K 1d
K 1d
K 5a
K 23
K 5a
K 23
K 5a
K 1b
K 5a
K 1b
K 5a
R 0 00016a59
R 1 00002a4e

// File: filelist.f
+incdir+.
tictactoePkg.sv
keyDecoder.sv
gameBoard.sv
lineChecker.sv
winArbiter.sv
boardBusSlave.sv
tictactoeTop.sv
tbChecker.sv
tbTictactoe.sv
